// ==== rtl/lc4_pkg.sv ====
// shared types, opcodes and decode helpers for the two-wide LC4 ALU core
// only ADD/MUL/SUB/ADDI, AND/NOT/OR/XOR/ANDI and CONST write a register
// any other encoding (DIV included) runs as an instruction with no write
`default_nettype none

package lc4_pkg;

    typedef logic [15:0] word_t;
    typedef logic [15:0] insn_t;
    typedef logic [2:0]  reg_sel_t;

    // the split rule is written for pairs, so this stays at 2
    localparam int N_LANES = 2;
    localparam int N_REGS  = 8;

    localparam logic [3:0] OP_ARITH = 4'b0001;
    localparam logic [3:0] OP_LOGIC = 4'b0101;
    localparam logic [3:0] OP_CONST = 4'b1001;

    // field positions
    localparam int OPC_LSB = 12;
    localparam int RD_LSB  = 9;
    localparam int RS_LSB  = 6;
    localparam int RT_LSB  = 0;
    localparam int SUB_LSB = 3;
    localparam int IMM_BIT = 5;

    function automatic logic [3:0] insn_opcode(insn_t insn);
        return insn[OPC_LSB +: 4];
    endfunction

    function automatic reg_sel_t insn_rd(insn_t insn);
        return insn[RD_LSB +: 3];
    endfunction

    function automatic reg_sel_t insn_rs(insn_t insn);
        return insn[RS_LSB +: 3];
    endfunction

    function automatic reg_sel_t insn_rt(insn_t insn);
        return insn[RT_LSB +: 3];
    endfunction

    function automatic logic [2:0] insn_subop(insn_t insn);
        return insn[SUB_LSB +: 3];
    endfunction

    function automatic word_t sext_imm5(insn_t insn);
        return {{11{insn[4]}}, insn[4:0]};
    endfunction

    function automatic word_t sext_imm9(insn_t insn);
        return {{7{insn[8]}}, insn[8:0]};
    endfunction

    function automatic logic insn_writes_rd(insn_t insn);
        logic [2:0] sub;
        sub = insn_subop(insn);
        case (insn_opcode(insn))
            // sub-op 011 in the arithmetic group is DIV, not kept
            OP_ARITH: return insn[IMM_BIT] || (sub inside {3'b000, 3'b001, 3'b010});
            OP_LOGIC: return insn[IMM_BIT] || !sub[2];
            OP_CONST: return 1'b1;
            default:  return 1'b0;
        endcase
    endfunction

    function automatic logic insn_reads_rs(insn_t insn);
        return (insn_opcode(insn) == OP_ARITH) || (insn_opcode(insn) == OP_LOGIC);
    endfunction

    function automatic logic insn_reads_rt(insn_t insn);
        logic is_not;
        is_not = (insn_opcode(insn) == OP_LOGIC) && (insn_subop(insn) == 3'b001);
        return insn_reads_rs(insn) && !insn[IMM_BIT] && !is_not;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/lc4_lane_ifs.sv ====
// lane-to-register-file bundles
// operand data comes back combinationally in the same cycle as the selects
// result data is only meaningful while we is set
`timescale 1ns/1ps
`default_nettype none

interface lane_operand_if;
    import lc4_pkg::*;

    reg_sel_t rs_sel;
    reg_sel_t rt_sel;
    word_t    rs_data;
    word_t    rt_data;

    modport lane (
        output rs_sel, rt_sel,
        input  rs_data, rt_data
    );

    modport regfile (
        input  rs_sel, rt_sel,
        output rs_data, rt_data
    );
endinterface

interface lane_result_if;
    import lc4_pkg::*;

    logic     valid;
    logic     we;
    reg_sel_t wsel;
    word_t    data;
    word_t    pc;
    insn_t    insn;

    modport lane (
        output valid, we, wsel, data, pc, insn
    );

    modport writeback (
        input  valid, we, wsel, data, pc, insn
    );
endinterface

`default_nettype wire

// ==== rtl/lc4_dispatch.sv ====
// pair fetch and issue for the two lanes
// i_insn_a/i_insn_b must be the words at o_cur_pc and o_cur_pc+1, same cycle
// lane B is held back when it reads the rd of lane A; it is refetched as A
// no stall input, the PC always moves by 1 or 2
`timescale 1ns/1ps
`default_nettype none

module lc4_dispatch #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  wire                  gwe,
    input  wire                  i_reset,
    output lc4_pkg::word_t       o_cur_pc,
    input  lc4_pkg::insn_t       i_insn_a,
    input  lc4_pkg::insn_t       i_insn_b,
    output logic                 o_issue_valid [lc4_pkg::N_LANES],
    output lc4_pkg::insn_t       o_issue_insn  [lc4_pkg::N_LANES],
    output lc4_pkg::word_t       o_issue_pc    [lc4_pkg::N_LANES]
);
    import lc4_pkg::*;

    word_t    pc_q;
    word_t    pc_next;
    reg_sel_t a_rd;
    logic     a_writes;
    logic     b_hits_rs;
    logic     b_hits_rt;
    logic     split;

    assign o_cur_pc = pc_q;

    // intra-pair RAW check, B against the destination of A
    assign a_rd      = insn_rd(i_insn_a);
    assign a_writes  = insn_writes_rd(i_insn_a);
    assign b_hits_rs = insn_reads_rs(i_insn_b) && (insn_rs(i_insn_b) == a_rd);
    assign b_hits_rt = insn_reads_rt(i_insn_b) && (insn_rt(i_insn_b) == a_rd);
    assign split     = a_writes && (b_hits_rs || b_hits_rt);

    assign pc_next = split ? (pc_q + 16'd1) : (pc_q + 16'd2);

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // issue slots, only the valids need clearing
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            o_issue_valid[0] <= 1'b0;
            o_issue_valid[1] <= 1'b0;
        end else begin
            o_issue_valid[0] <= 1'b1;
            o_issue_valid[1] <= !split;
        end
        o_issue_insn[0] <= i_insn_a;
        o_issue_insn[1] <= i_insn_b;
        o_issue_pc[0]   <= pc_q;
        o_issue_pc[1]   <= pc_q + 16'd1;
    end

    // fetch never stalls, so every step is one instruction or a full pair
    property p_pc_step;
        @(posedge gwe) disable iff (i_reset)
        !$past(i_reset) |->
            ((word_t'(pc_q - $past(pc_q)) == 16'd1) ||
             (word_t'(pc_q - $past(pc_q)) == 16'd2));
    endproperty

    a_pc_step: assert property (p_pc_step)
        else $error("pc moved by other than 1 or 2");

endmodule

`default_nettype wire

// ==== rtl/lc4_exec_lane.sv ====
// one execution lane, X register, decode, ALU and W register
// operands come from the write-through register file, so no bypass network here
// no-write encodings still retire with we low
`timescale 1ns/1ps
`default_nettype none

module lc4_exec_lane (
    input  wire                   gwe,
    input  wire                   i_reset,
    input  wire                   i_issue_valid,
    input  lc4_pkg::insn_t        i_issue_insn,
    input  lc4_pkg::word_t        i_issue_pc,
    lane_operand_if.lane          ops,
    lane_result_if.lane           res
);
    import lc4_pkg::*;

    logic       x_valid;
    insn_t      x_insn;
    word_t      x_pc;
    logic [3:0] x_opc;
    logic [2:0] x_sub;
    logic       x_imm;
    logic       x_we;
    word_t      rs_val;
    word_t      rt_val;
    word_t      alu_out;

    // X stage register
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            x_valid <= 1'b0;
        end else begin
            x_valid <= i_issue_valid;
        end
        x_insn <= i_issue_insn;
        x_pc   <= i_issue_pc;
    end

    assign x_opc = insn_opcode(x_insn);
    assign x_sub = insn_subop(x_insn);
    assign x_imm = x_insn[IMM_BIT];
    assign x_we  = x_valid && insn_writes_rd(x_insn);

    // selects go out even for unused operands, harmless on the read side
    assign ops.rs_sel = insn_rs(x_insn);
    assign ops.rt_sel = insn_rt(x_insn);
    assign rs_val     = ops.rs_data;
    assign rt_val     = ops.rt_data;

    always_comb begin
        alu_out = '0;
        case (x_opc)
            OP_ARITH: begin
                if (x_imm) begin
                    alu_out = rs_val + sext_imm5(x_insn);
                end else begin
                    case (x_sub)
                        3'b000:  alu_out = rs_val + rt_val;
                        3'b001:  alu_out = rs_val * rt_val;
                        3'b010:  alu_out = rs_val - rt_val;
                        // DIV and the rest are dropped
                        default: alu_out = '0;
                    endcase
                end
            end
            OP_LOGIC: begin
                if (x_imm) begin
                    alu_out = rs_val & sext_imm5(x_insn);
                end else begin
                    case (x_sub)
                        3'b000:  alu_out = rs_val & rt_val;
                        3'b001:  alu_out = ~rs_val;
                        3'b010:  alu_out = rs_val | rt_val;
                        3'b011:  alu_out = rs_val ^ rt_val;
                        default: alu_out = '0;
                    endcase
                end
            end
            OP_CONST: alu_out = sext_imm9(x_insn);
            default:  alu_out = '0;
        endcase
    end

    // W stage register, feeds the register file and the retire ports
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            res.valid <= 1'b0;
            res.we    <= 1'b0;
        end else begin
            res.valid <= x_valid;
            res.we    <= x_we;
        end
        res.wsel <= insn_rd(x_insn);
        res.data <= alu_out;
        res.pc   <= x_pc;
        res.insn <= x_insn;
    end

    a_we_needs_valid: assert property (@(posedge gwe) disable iff (i_reset)
        res.we |-> res.valid)
        else $error("register write from an invalid W slot");

endmodule

`default_nettype wire

// ==== rtl/lc4_writeback.sv ====
// eight-entry register file with one write port per lane
// lane B wins when both lanes write the same register, in the array and
// on the write-through read path alike
// retire outputs show the W slots directly, one cycle before the write lands
`timescale 1ns/1ps
`default_nettype none

module lc4_writeback (
    input  wire                     gwe,
    input  wire                     i_reset,
    lane_operand_if.regfile         ops [lc4_pkg::N_LANES],
    lane_result_if.writeback        res [lc4_pkg::N_LANES],
    output logic                    o_retire_valid [lc4_pkg::N_LANES],
    output lc4_pkg::word_t          o_retire_pc    [lc4_pkg::N_LANES],
    output lc4_pkg::insn_t          o_retire_insn  [lc4_pkg::N_LANES],
    output logic                    o_regfile_we   [lc4_pkg::N_LANES],
    output lc4_pkg::reg_sel_t       o_regfile_wsel [lc4_pkg::N_LANES],
    output lc4_pkg::word_t          o_regfile_data [lc4_pkg::N_LANES]
);
    import lc4_pkg::*;

    word_t    rf     [N_REGS];
    logic     w_we   [N_LANES];
    reg_sel_t w_sel  [N_LANES];
    word_t    w_data [N_LANES];

    // array value, overridden by W writes in lane order so B lands last
    function automatic word_t wt_read(reg_sel_t sel);
        word_t val;
        val = rf[sel];
        for (int k = 0; k < N_LANES; k++) begin
            if (w_we[k] && (w_sel[k] == sel)) begin
                val = w_data[k];
            end
        end
        return val;
    endfunction

    for (genvar l = 0; l < N_LANES; l++) begin : g_lane
        assign w_we[l]   = res[l].we;
        assign w_sel[l]  = res[l].wsel;
        assign w_data[l] = res[l].data;

        always_comb begin
            ops[l].rs_data = wt_read(ops[l].rs_sel);
            ops[l].rt_data = wt_read(ops[l].rt_sel);
        end

        assign o_retire_valid[l] = res[l].valid;
        assign o_retire_pc[l]    = res[l].pc;
        assign o_retire_insn[l]  = res[l].insn;
        assign o_regfile_we[l]   = res[l].we;
        assign o_regfile_wsel[l] = res[l].wsel;
        assign o_regfile_data[l] = res[l].data;
    end

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int r = 0; r < N_REGS; r++) begin
                rf[r] <= '0;
            end
        end else begin
            for (int k = 0; k < N_LANES; k++) begin
                if (w_we[k]) begin
                    rf[w_sel[k]] <= w_data[k];
                end
            end
        end
    end

    // dispatch only ever drops lane B, so B never retires alone
    a_b_with_a: assert property (@(posedge gwe) disable iff (i_reset)
        res[1].valid |-> res[0].valid)
        else $error("lane B retired without lane A");

endmodule

`default_nettype wire

// ==== rtl/lc4_superscalar_core.sv ====
// two-wide in-order LC4 ALU core, stages F, issue, X and W
// instruction memory is outside; it must return the words at o_cur_pc and
// o_cur_pc+1 combinationally
// a pair shows on the retire ports two cycles after the edge that fetched it
`timescale 1ns/1ps
`default_nettype none

module lc4_superscalar_core #(
    parameter lc4_pkg::word_t RESET_PC = 16'h8200
) (
    input  wire                    gwe,
    input  wire                    i_reset,
    output lc4_pkg::word_t         o_cur_pc,
    input  lc4_pkg::insn_t         i_insn_a,
    input  lc4_pkg::insn_t         i_insn_b,
    output logic                   o_retire_valid_a,
    output logic                   o_retire_valid_b,
    output lc4_pkg::word_t         o_retire_pc_a,
    output lc4_pkg::word_t         o_retire_pc_b,
    output lc4_pkg::insn_t         o_retire_insn_a,
    output lc4_pkg::insn_t         o_retire_insn_b,
    output logic                   o_regfile_we_a,
    output logic                   o_regfile_we_b,
    output lc4_pkg::reg_sel_t      o_regfile_wsel_a,
    output lc4_pkg::reg_sel_t      o_regfile_wsel_b,
    output lc4_pkg::word_t         o_regfile_data_a,
    output lc4_pkg::word_t         o_regfile_data_b
);
    import lc4_pkg::*;

    logic     issue_valid  [N_LANES];
    insn_t    issue_insn   [N_LANES];
    word_t    issue_pc     [N_LANES];
    logic     retire_valid [N_LANES];
    word_t    retire_pc    [N_LANES];
    insn_t    retire_insn  [N_LANES];
    logic     rf_we        [N_LANES];
    reg_sel_t rf_wsel      [N_LANES];
    word_t    rf_data      [N_LANES];

    lane_operand_if ops [N_LANES] ();
    lane_result_if  res [N_LANES] ();

    lc4_dispatch #(
        .RESET_PC (RESET_PC)
    ) u_dispatch (
        .gwe           (gwe),
        .i_reset       (i_reset),
        .o_cur_pc      (o_cur_pc),
        .i_insn_a      (i_insn_a),
        .i_insn_b      (i_insn_b),
        .o_issue_valid (issue_valid),
        .o_issue_insn  (issue_insn),
        .o_issue_pc    (issue_pc)
    );

    // index 0 is lane A, index 1 is lane B
    for (genvar l = 0; l < N_LANES; l++) begin : g_lane
        lc4_exec_lane u_lane (
            .gwe           (gwe),
            .i_reset       (i_reset),
            .i_issue_valid (issue_valid[l]),
            .i_issue_insn  (issue_insn[l]),
            .i_issue_pc    (issue_pc[l]),
            .ops           (ops[l]),
            .res           (res[l])
        );
    end

    lc4_writeback u_writeback (
        .gwe            (gwe),
        .i_reset        (i_reset),
        .ops            (ops),
        .res            (res),
        .o_retire_valid (retire_valid),
        .o_retire_pc    (retire_pc),
        .o_retire_insn  (retire_insn),
        .o_regfile_we   (rf_we),
        .o_regfile_wsel (rf_wsel),
        .o_regfile_data (rf_data)
    );

    assign o_retire_valid_a = retire_valid[0];
    assign o_retire_valid_b = retire_valid[1];
    assign o_retire_pc_a    = retire_pc[0];
    assign o_retire_pc_b    = retire_pc[1];
    assign o_retire_insn_a  = retire_insn[0];
    assign o_retire_insn_b  = retire_insn[1];
    assign o_regfile_we_a   = rf_we[0];
    assign o_regfile_we_b   = rf_we[1];
    assign o_regfile_wsel_a = rf_wsel[0];
    assign o_regfile_wsel_b = rf_wsel[1];
    assign o_regfile_data_a = rf_data[0];
    assign o_regfile_data_b = rf_data[1];

endmodule

`default_nettype wire

// ==== sim/tb_lc4_superscalar.sv ====
// testbench for the two-wide LC4 ALU core
// instruction memory is a 200-word program at RESET_PC, NOPs (0000) beyond it
// a sequential ISA model checks every retired instruction, lane A first
// the run stops once the whole program has retired or at the cycle limit
`timescale 1ns/1ps
`default_nettype none

module tb_lc4_superscalar;
    import lc4_pkg::*;

    localparam word_t       RESET_PC     = 16'h8200;
    localparam int          PROG_LEN     = 200;
    localparam int          MAX_CYCLES   = 3 * PROG_LEN;
    localparam int          RESET_CYCLES = 10;
    localparam int          N_TESTS      = 6;
    localparam int unsigned SEED         = 32'h96750b52;
    localparam insn_t       NOP_INSN     = 16'h0000;

    logic     gwe;
    logic     i_reset;
    word_t    o_cur_pc;
    insn_t    i_insn_a, i_insn_b;
    logic     o_retire_valid_a, o_retire_valid_b;
    word_t    o_retire_pc_a, o_retire_pc_b;
    insn_t    o_retire_insn_a, o_retire_insn_b;
    logic     o_regfile_we_a, o_regfile_we_b;
    reg_sel_t o_regfile_wsel_a, o_regfile_wsel_b;
    word_t    o_regfile_data_a, o_regfile_data_b;

    insn_t       prog [PROG_LEN];
    word_t       m_regs [8];
    int          m_idx;
    int          cur_test;
    int          cycles;
    int          errs [N_TESTS];
    int          checks [N_TESTS];
    string       tname [N_TESTS] = '{"reset", "retire_match", "pc_order",
                                     "pair_split", "dep_chain", "same_rd"};

    lc4_superscalar_core #(.RESET_PC(RESET_PC)) uut (.*);

    initial begin
        gwe = 1'b0;
        forever #10 gwe = ~gwe;
    end

    function automatic insn_t enc_rrr(logic [3:0] opc, int rd, int rs, logic [2:0] sub, int rt);
        return {opc, 3'(rd), 3'(rs), sub, 3'(rt)};
    endfunction

    function automatic insn_t enc_imm(logic [3:0] opc, int rd, int rs, int imm);
        return {opc, 3'(rd), 3'(rs), 1'b1, 5'(imm)};
    endfunction

    function automatic insn_t enc_const(int rd, int imm);
        return {4'b1001, 3'(rd), 9'(imm)};
    endfunction

    function automatic insn_t random_insn();
        int k, rd, rs, rt;
        k  = $urandom % 12;
        rd = $urandom % 8;
        rs = $urandom % 8;
        rt = $urandom % 8;
        case (k)
            0:  return enc_rrr(4'b0001, rd, rs, 3'b000, rt);
            1:  return enc_rrr(4'b0001, rd, rs, 3'b001, rt);
            2:  return enc_rrr(4'b0001, rd, rs, 3'b010, rt);
            3:  return enc_imm(4'b0001, rd, rs, $urandom);
            4:  return enc_rrr(4'b0101, rd, rs, 3'b000, rt);
            5:  return enc_rrr(4'b0101, rd, rs, 3'b001, rt);
            6:  return enc_rrr(4'b0101, rd, rs, 3'b010, rt);
            7:  return enc_rrr(4'b0101, rd, rs, 3'b011, rt);
            8:  return enc_imm(4'b0101, rd, rs, $urandom);
            9:  return enc_const(rd, $urandom);
            // DIV, dropped from the core
            10: return enc_rrr(4'b0001, rd, rs, 3'b011, rt);
            default: return {4'b0000, 12'($urandom)};
        endcase
    endfunction

    function automatic insn_t fetch(word_t addr);
        word_t off;
        off = addr - RESET_PC;
        if (off < word_t'(PROG_LEN)) begin
            return prog[off];
        end else begin
            return NOP_INSN;
        end
    endfunction

    // reference ALU, returns the write flag and the result in val
    function automatic logic model_exec(insn_t insn, output word_t val);
        word_t rs, rt, imm5;
        rs   = m_regs[insn[8:6]];
        rt   = m_regs[insn[2:0]];
        imm5 = {{11{insn[4]}}, insn[4:0]};
        val  = '0;
        case (insn[15:12])
            4'b0001: begin
                if (insn[5]) begin
                    val = rs + imm5;
                    return 1'b1;
                end
                case (insn[5:3])
                    3'b000:  val = rs + rt;
                    3'b001:  val = rs * rt;
                    3'b010:  val = rs - rt;
                    default: return 1'b0;
                endcase
                return 1'b1;
            end
            4'b0101: begin
                if (insn[5]) begin
                    val = rs & imm5;
                    return 1'b1;
                end
                case (insn[5:3])
                    3'b000:  val = rs & rt;
                    3'b001:  val = ~rs;
                    3'b010:  val = rs | rt;
                    3'b011:  val = rs ^ rt;
                    default: return 1'b0;
                endcase
                return 1'b1;
            end
            4'b1001: begin
                val = {{7{insn[8]}}, insn[8:0]};
                return 1'b1;
            end
            default: return 1'b0;
        endcase
    endfunction

    // true when b reads a register that a writes
    function automatic logic depends(insn_t a, insn_t b);
        word_t dummy;
        logic  a_we, rd_rs, rd_rt;
        a_we  = model_exec(a, dummy);
        rd_rs = (b[15:12] == 4'b0001) || (b[15:12] == 4'b0101);
        rd_rt = rd_rs && !b[5] && !((b[15:12] == 4'b0101) && (b[5:3] == 3'b001));
        return a_we && ((rd_rs && b[8:6] == a[11:9]) || (rd_rt && b[2:0] == a[11:9]));
    endfunction

    task automatic check_word(input string what, input word_t exp, input word_t act);
        checks[cur_test]++;
        if (act !== exp) begin
            errs[cur_test]++;
            $display("FAIL %s %s: expected %h, actual %h", tname[cur_test], what, exp, act);
        end
    endtask

    task automatic check_insn(input string what, input insn_t exp, input insn_t act);
        checks[cur_test]++;
        if (act !== exp) begin
            errs[cur_test]++;
            $display("FAIL %s %s: expected %h, actual %h", tname[cur_test], what, exp, act);
        end
    endtask

    task automatic check_sel(input string what, input reg_sel_t exp, input reg_sel_t act);
        checks[cur_test]++;
        if (act !== exp) begin
            errs[cur_test]++;
            $display("FAIL %s %s: expected %0d, actual %0d", tname[cur_test], what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks[cur_test]++;
        if (act !== exp) begin
            errs[cur_test]++;
            $display("FAIL %s %s: expected %b, actual %b", tname[cur_test], what, exp, act);
        end
    endtask

    task automatic retire_one(input string lane, input word_t pc, input insn_t insn,
                              input logic we, input reg_sel_t wsel, input word_t data);
        insn_t exp_insn;
        word_t exp_val;
        logic  exp_we;
        exp_insn = fetch(RESET_PC + word_t'(m_idx));
        cur_test = 2;
        check_word({"pc_", lane}, RESET_PC + word_t'(m_idx), pc);
        // prefix slots 2..5 form the chain, 7..10 the same-rd pair and its reader
        cur_test = (m_idx >= 2 && m_idx <= 5) ? 4 : (m_idx >= 7 && m_idx <= 10) ? 5 : 1;
        check_insn({"insn_", lane}, exp_insn, insn);
        exp_we = model_exec(exp_insn, exp_val);
        check_bit({"we_", lane}, exp_we, we);
        if (exp_we) begin
            check_sel({"wsel_", lane}, reg_sel_t'(exp_insn[11:9]), wsel);
            check_word({"data_", lane}, exp_val, data);
            m_regs[exp_insn[11:9]] = exp_val;
        end
        m_idx++;
    endtask

    task automatic check_retire();
        insn_t a_exp;
        a_exp = fetch(RESET_PC + word_t'(m_idx));
        if (o_retire_valid_b && !o_retire_valid_a) begin
            cur_test = 2;
            check_bit("valid_a_with_b", 1'b1, o_retire_valid_a);
        end
        if (o_retire_valid_a) begin
            retire_one("a", o_retire_pc_a, o_retire_insn_a, o_regfile_we_a,
                       o_regfile_wsel_a, o_regfile_data_a);
            cur_test = 3;
            if (o_retire_valid_b) begin
                check_bit("b_reads_a_rd", 1'b0, depends(a_exp, fetch(RESET_PC + word_t'(m_idx))));
                cur_test = 2;
                check_word("pc_b_vs_a", RESET_PC + word_t'(m_idx), o_retire_pc_b);
                retire_one("b", o_retire_pc_b, o_retire_insn_b, o_regfile_we_b,
                           o_regfile_wsel_b, o_regfile_data_b);
            end else begin
                // a lone lane A is only legal on an intra-pair dependence
                check_bit("split_has_dep", 1'b1,
                          depends(a_exp, fetch(RESET_PC + word_t'(m_idx))));
            end
        end
    endtask

    task automatic check_reset_state();
        cur_test = 0;
        check_word("cur_pc", RESET_PC, o_cur_pc);
        check_bit("retire_valid_a", 1'b0, o_retire_valid_a);
        check_bit("retire_valid_b", 1'b0, o_retire_valid_b);
    endtask

    task automatic report_test(input int t);
        $display("test %-12s %s  (%0d checks, %0d errors)", tname[t],
                 (errs[t] == 0 && checks[t] > 0) ? "ok" : "FAILED", checks[t], errs[t]);
    endtask

    initial begin
        int unsigned seed_dummy;
        int          total_errs;
        int          total_checks;
        logic        timed_out;
        seed_dummy = $urandom(SEED);
        i_reset    = 1'b1;
        i_insn_a   = NOP_INSN;
        i_insn_b   = NOP_INSN;
        m_idx      = 0;
        cycles     = 0;
        timed_out  = 1'b0;
        for (int t = 0; t < N_TESTS; t++) begin
            errs[t]   = 0;
            checks[t] = 0;
        end
        for (int r = 0; r < 8; r++) begin
            m_regs[r] = '0;
        end

        // directed prefix, pairs start at even offsets until the first split
        prog[0]  = enc_const(1, 5);
        prog[1]  = enc_const(2, -3);
        prog[2]  = enc_rrr(4'b0001, 3, 1, 3'b000, 2);
        prog[3]  = enc_rrr(4'b0001, 4, 3, 3'b001, 3);
        prog[4]  = enc_rrr(4'b0001, 5, 4, 3'b010, 1);
        prog[5]  = enc_rrr(4'b0101, 6, 5, 3'b011, 2);
        prog[6]  = enc_const(7, 9'h0aa);
        prog[7]  = enc_rrr(4'b0001, 7, 1, 3'b000, 2);
        prog[8]  = enc_rrr(4'b0101, 7, 2, 3'b010, 1);
        prog[9]  = enc_imm(4'b0001, 0, 7, 1);
        prog[10] = enc_rrr(4'b0101, 1, 0, 3'b001, 0);
        prog[11] = enc_imm(4'b0101, 2, 1, -2);
        for (int i = 12; i < PROG_LEN; i++) begin
            prog[i] = random_insn();
        end

        repeat (RESET_CYCLES) begin
            @(posedge gwe);
            #1;
            i_insn_a = fetch(o_cur_pc);
            i_insn_b = fetch(o_cur_pc + 16'd1);
            @(negedge gwe);
            check_reset_state();
        end
        @(posedge gwe);
        #1;
        i_reset  = 1'b0;
        i_insn_a = fetch(o_cur_pc);
        i_insn_b = fetch(o_cur_pc + 16'd1);
        @(negedge gwe);
        check_reset_state();
        report_test(0);

        while (m_idx < PROG_LEN && cycles < MAX_CYCLES) begin
            @(posedge gwe);
            #1;
            i_insn_a = fetch(o_cur_pc);
            i_insn_b = fetch(o_cur_pc + 16'd1);
            @(negedge gwe);
            cycles++;
            check_retire();
        end
        if (m_idx < PROG_LEN) begin
            timed_out = 1'b1;
            $display("ERROR: timeout after %0d cycles, only %0d of %0d instructions retired",
                     cycles, m_idx, PROG_LEN);
        end

        total_errs   = 0;
        total_checks = 0;
        for (int t = 1; t < N_TESTS; t++) begin
            report_test(t);
        end
        for (int t = 0; t < N_TESTS; t++) begin
            total_errs   += errs[t];
            total_checks += checks[t];
        end
        $display("tests %0d, checks %0d, errors %0d, cycles %0d, retired %0d",
                 N_TESTS, total_checks, total_errs, cycles, m_idx);
        if (total_errs == 0 && !timed_out) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
rtl/lc4_pkg.sv
rtl/lc4_lane_ifs.sv
rtl/lc4_dispatch.sv
rtl/lc4_exec_lane.sv
rtl/lc4_writeback.sv
rtl/lc4_superscalar_core.sv
sim/tb_lc4_superscalar.sv

// ==== Bender.yml ====
package:
  name: lc4_superscalar

sources:
  - rtl/lc4_pkg.sv
  - rtl/lc4_lane_ifs.sv
  - rtl/lc4_dispatch.sv
  - rtl/lc4_exec_lane.sv
  - rtl/lc4_writeback.sv
  - rtl/lc4_superscalar_core.sv
  - target: simulation
    files:
      - sim/tb_lc4_superscalar.sv
